// File: verilog/addr_macros.svh
`ifndef ADDR_MACROS_SVH
`define ADDR_MACROS_SVH

//////////////////////////////////////////////////////////////////////
// address path widths and decode fields
//////////////////////////////////////////////////////////////////////

// width of the address register and of the address bus
`define ADDR_W 16

// device page bits, all zero for a system or I/O device access
`define DEV_PAGE_HI 15
`define DEV_PAGE_LO 11

// device select field, value 0 is the system device
`define DEV_SEL_HI 10
`define DEV_SEL_LO 8

// bits compared by the autoindex detector
`define AIDX_HI 15
`define AIDX_LO 7

// 0000_0000_1 in bits 15 to 7 marks page 0x0080 to 0x00ff
`define AIDX_PATTERN 9'b0_0000_0001

`endif

// File: verilog/addr_pkg.sv
`default_nettype none

`include "addr_macros.svh"

//////////////////////////////////////////////////////////////////////
// types passed between the address path stages
//////////////////////////////////////////////////////////////////////

package addr_pkg;

   // one machine address
   typedef logic [`ADDR_W-1:0] addr_t;

   // stage 1 item
   // address register value and the cycle controls seen with it
   typedef struct packed {
      addr_t addr;
      // this cycle's write strobe was low
      logic  loaded;
      // active low memory cycle
      logic  nmem;
      // active low I/O cycle
      logic  nio;
      // active low end of instruction
      logic  nend;
   } ar_stage_t;

   // stage 2 item
   // decoded selects and the autoindex state for one address
   typedef struct packed {
      addr_t      addr;
      // memory or I/O cycle running
      logic       bus_en;
      logic       nsysdev;
      // devices 3 down to 1
      logic [3:1] niodev;
      logic       naindex;
   } dec_stage_t;

   // idle stage 1 item
   localparam ar_stage_t AR_STAGE_IDLE = '{
      addr: '0, loaded: 1'b0, nmem: 1'b1, nio: 1'b1, nend: 1'b1
   };

   // idle stage 2 item, every select released
   localparam dec_stage_t DEC_STAGE_IDLE = '{
      addr: '0, bus_en: 1'b0, nsysdev: 1'b1, niodev: 3'b111, naindex: 1'b1
   };

endpackage

`default_nettype wire

// File: verilog/addr_register.sv
`default_nettype none

//////////////////////////////////////////////////////////////////////
// stage 1 of the address path
//////////////////////////////////////////////////////////////////////

// the address register of the processor board
// loads from the internal bus while the write strobe is low
// the cycle controls are registered on the same edge so they
// travel down the pipe together with the address they belong to

module addr_register (
   input  logic                clk,
   input  logic                arst_n,
   // internal bus
   input  addr_pkg::addr_t     ibus,
   // active low write strobe for the register
   input  logic                nwar,
   // cycle controls
   input  logic                nmem,
   input  logic                nio,
   input  logic                nend,
   // register value straight out
   output addr_pkg::addr_t     ar,
   // item handed to the decode stage
   output addr_pkg::ar_stage_t ar_stage
);

   // stage 1 register
   addr_pkg::ar_stage_t stage_q;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         // empty register, no cycle, not loaded
         stage_q <= addr_pkg::AR_STAGE_IDLE;
      end else begin
         // address only moves on a write strobe
         // otherwise the old value is kept
         if (!nwar) begin
            stage_q.addr <= ibus;
         end

         // fresh address marker for the autoindex detector
         stage_q.loaded <= ~nwar;

         // controls of this edge stay beside the address
         stage_q.nmem <= nmem;
         stage_q.nio  <= nio;
         stage_q.nend <= nend;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // outputs
   //////////////////////////////////////////////////////////////////////

   // ar is visible one edge after the strobe
   assign ar = stage_q.addr;

   // whole item to stage 2
   assign ar_stage = stage_q;

endmodule

`default_nettype wire

// File: verilog/addr_decode.sv
`default_nettype none

`include "addr_macros.svh"

//////////////////////////////////////////////////////////////////////
// stage 2 of the address path
//////////////////////////////////////////////////////////////////////

// device select decoder and autoindex detector
// device selects need an I/O cycle and an address in the device page
// the select field then picks one of eight lines like a '138
// only the lowest four lines are wired to devices
//
// autoindex page is 0x0080 to 0x00ff
// the flag is held until end of instruction because indirect
// accesses overwrite the address register mid-instruction

module addr_decode (
   input  logic                 clk,
   input  logic                 arst_n,
   // item from the address register stage
   input  addr_pkg::ar_stage_t  ar_stage,
   // item for the bus drive stage
   output addr_pkg::dec_stage_t dec_stage
);

   //////////////////////////////////////////////////////////////////////
   // device select decode
   //////////////////////////////////////////////////////////////////////

   // address in the device page
   logic                                dev_page_zero;
   // device number from the address
   logic [`DEV_SEL_HI-`DEV_SEL_LO:0]    dev_sel;
   // I/O cycle to a device page address
   logic                                dev_hit;
   // all eight demux outputs, active low
   logic [7:0]                          nsel;

   // all page bits must be zero
   assign dev_page_zero = ~|ar_stage.addr[`DEV_PAGE_HI:`DEV_PAGE_LO];

   assign dev_sel = ar_stage.addr[`DEV_SEL_HI:`DEV_SEL_LO];

   // nio works as the enable of the demux
   assign dev_hit = ~ar_stage.nio & dev_page_zero;

   // one low line for the selected device
   // values 4 to 7 drive lines with nothing behind them
   assign nsel = dev_hit ? ~(8'b0000_0001 << dev_sel) : 8'hff;

   //////////////////////////////////////////////////////////////////////
   // autoindex detect
   //////////////////////////////////////////////////////////////////////

   // address bits 15 to 7 equal the autoindex pattern
   logic aidx_match;
   // freshly loaded address in the autoindex page
   logic aidx_set;
   // end of instruction
   logic aidx_clr;
   // next value of the held flag
   logic naindex_next;

   assign aidx_match = (ar_stage.addr[`AIDX_HI:`AIDX_LO] == `AIDX_PATTERN);

   // only a new load may set the flag
   assign aidx_set = ar_stage.loaded & aidx_match;

   assign aidx_clr = ~ar_stage.nend;

   // stage register, its naindex field is the held flag
   addr_pkg::dec_stage_t stage_q;

   // clear beats set, otherwise hold
   // a later non-matching load leaves the flag alone
   always_comb begin
      if (aidx_clr) begin
         naindex_next = 1'b1;
      end else if (aidx_set) begin
         naindex_next = 1'b0;
      end else begin
         naindex_next = stage_q.naindex;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // stage register
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         stage_q <= addr_pkg::DEC_STAGE_IDLE;
      end else begin
         stage_q.addr    <= ar_stage.addr;
         // drive the bus for memory or I/O cycles
         stage_q.bus_en  <= ~(ar_stage.nmem & ar_stage.nio);
         // line 0 is the system device
         stage_q.nsysdev <= nsel[0];
         // lines 3 to 1 are I/O devices 3 to 1
         stage_q.niodev  <= nsel[3:1];
         stage_q.naindex <= naindex_next;
      end
   end

   assign dec_stage = stage_q;

endmodule

`default_nettype wire

// File: verilog/addr_bus_drive.sv
`default_nettype none

//////////////////////////////////////////////////////////////////////
// stage 3 of the address path
//////////////////////////////////////////////////////////////////////

// address bus driver
// the bus is driven during memory and I/O cycles only
// between cycles the bus keeps the last driven value
// which stands in for bus hold on the real backplane
// selects and autoindex are registered here too so that
// all outputs move on the same edge as the bus

module addr_bus_drive (
   input  logic                 clk,
   input  logic                 arst_n,
   // item from the decode stage
   input  addr_pkg::dec_stage_t dec_stage,
   // address bus value and its enable
   output addr_pkg::addr_t      ab,
   output logic                 ab_en,
   // device selects, active low
   output logic                 nsysdev,
   output logic                 niodev1,
   output logic                 niodev2,
   output logic                 niodev3,
   // autoindex, active low
   output logic                 naindex
);

   //////////////////////////////////////////////////////////////////////
   // bus value and enable
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ab    <= '0;
         ab_en <= 1'b0;
      end else begin
         // new value only while a cycle runs
         if (dec_stage.bus_en) begin
            ab <= dec_stage.addr;
         end
         ab_en <= dec_stage.bus_en;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // selects
   //////////////////////////////////////////////////////////////////////

   // released on reset
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         nsysdev <= 1'b1;
         niodev1 <= 1'b1;
         niodev2 <= 1'b1;
         niodev3 <= 1'b1;
         naindex <= 1'b1;
      end else begin
         nsysdev <= dec_stage.nsysdev;
         niodev1 <= dec_stage.niodev[1];
         niodev2 <= dec_stage.niodev[2];
         niodev3 <= dec_stage.niodev[3];
         naindex <= dec_stage.naindex;
      end
   end

endmodule

`default_nettype wire

// File: verilog/addr_path_top.sv
`default_nettype none

//////////////////////////////////////////////////////////////////////
// address path of the processor board
//////////////////////////////////////////////////////////////////////

// three stages in a row
//   addr_register   address register and cycle controls
//   addr_decode     device selects and autoindex flag
//   addr_bus_drive  address bus with hold and output selects
// a new item enters every clock, nothing stalls
// bus and select outputs trail the inputs by three edges

module addr_path_top (
   input  logic            clk,
   input  logic            arst_n,
   // internal bus and register strobe
   input  addr_pkg::addr_t ibus,
   input  logic            nwar,
   // cycle controls
   input  logic            nmem,
   input  logic            nio,
   input  logic            nend,
   // address register
   output addr_pkg::addr_t ar,
   // address bus
   output addr_pkg::addr_t ab,
   output logic            ab_en,
   // device selects and autoindex
   output logic            nsysdev,
   output logic            niodev1,
   output logic            niodev2,
   output logic            niodev3,
   output logic            naindex
);

   // stage 1 to stage 2
   addr_pkg::ar_stage_t  ar_stage;
   // stage 2 to stage 3
   addr_pkg::dec_stage_t dec_stage;

   addr_register addr_register_inst (
      .clk      (clk),
      .arst_n   (arst_n),
      .ibus     (ibus),
      .nwar     (nwar),
      .nmem     (nmem),
      .nio      (nio),
      .nend     (nend),
      .ar       (ar),
      .ar_stage (ar_stage)
   );

   addr_decode addr_decode_inst (
      .clk       (clk),
      .arst_n    (arst_n),
      .ar_stage  (ar_stage),
      .dec_stage (dec_stage)
   );

   addr_bus_drive addr_bus_drive_inst (
      .clk       (clk),
      .arst_n    (arst_n),
      .dec_stage (dec_stage),
      .ab        (ab),
      .ab_en     (ab_en),
      .nsysdev   (nsysdev),
      .niodev1   (niodev1),
      .niodev2   (niodev2),
      .niodev3   (niodev3),
      .naindex   (naindex)
   );

endmodule

`default_nettype wire

// File: bench/addr_path_assertions.sv
`default_nettype none

//////////////////////////////////////////////////////////////////////
// protocol checks on the address path outputs
//////////////////////////////////////////////////////////////////////

module addr_path_assertions (
   input logic            clk,
   input logic            arst_n,
   input addr_pkg::addr_t ar,
   input addr_pkg::addr_t ab,
   input logic            ab_en,
   input logic            nsysdev,
   input logic            niodev1,
   input logic            niodev2,
   input logic            niodev3,
   input logic            naindex
);

   timeunit 1ns;
   timeprecision 1ps;

   // number of failed checks so far
   int fail_count = 0;

   // at most one device line low
   one_select: assert property (@(posedge clk) disable iff (!arst_n)
      $onehot0({~nsysdev, ~niodev1, ~niodev2, ~niodev3}))
      else begin
         fail_count++;
         $error("more than one device select is low at once");
      end

   // selects only come with an I/O cycle so the bus is driven too
   select_needs_bus: assert property (@(posedge clk) disable iff (!arst_n)
      (!nsysdev || !niodev1 || !niodev2 || !niodev3) |-> ab_en)
      else begin
         fail_count++;
         $error("a device select is low while the address bus is not driven");
      end

   // bus hold between cycles
   bus_hold: assert property (@(posedge clk) disable iff (!arst_n)
      !ab_en |-> $stable(ab))
      else begin
         fail_count++;
         $error("address bus moved while its enable was low");
      end

   // everything released in reset
   reset_idle: assert property (@(posedge clk)
      !arst_n |-> (ar == '0 && ab == '0 && !ab_en && nsysdev && niodev1 &&
                   niodev2 && niodev3 && naindex))
      else begin
         fail_count++;
         $error("an output is not inactive during reset");
      end

endmodule

bind addr_path_top addr_path_assertions addr_path_assertions_inst (
   .clk     (clk),
   .arst_n  (arst_n),
   .ar      (ar),
   .ab      (ab),
   .ab_en   (ab_en),
   .nsysdev (nsysdev),
   .niodev1 (niodev1),
   .niodev2 (niodev2),
   .niodev3 (niodev3),
   .naindex (naindex)
);

`default_nettype wire

// File: bench/addr_path_tb.sv
`default_nettype none

`include "addr_macros.svh"

module addr_path_tb;

   timeunit 1ns;
   timeprecision 1ps;

   //////////////////////////////////////////////////////////////////////
   // settings and signals
   //////////////////////////////////////////////////////////////////////

   localparam int CLK_HALF      = 4;
   localparam int RESET_CYCLES  = 10;
   localparam int RANDOM_CYCLES = 2000;
   // random run plus directed tests and reset with margin
   localparam int CYCLE_LIMIT   = 3000;

   // one set of bus and select outputs
   typedef struct packed {
      addr_pkg::addr_t ab;
      logic            ab_en;
      logic            nsysdev;
      logic [3:1]      niodev;
      logic            naindex;
   } out_set_t;

   localparam out_set_t OUT_IDLE = '{
      ab: '0, ab_en: 1'b0, nsysdev: 1'b1, niodev: 3'b111, naindex: 1'b1
   };

   logic            clk;
   logic            arst_n;
   addr_pkg::addr_t ibus;
   logic            nwar;
   logic            nmem;
   logic            nio;
   logic            nend;
   addr_pkg::addr_t ar;
   addr_pkg::addr_t ab;
   logic            ab_en;
   logic            nsysdev;
   logic            niodev1;
   logic            niodev2;
   logic            niodev3;
   logic            naindex;

   int              errors;
   int              tests;
   int              test_start_errors;
   int              assert_fails_seen;
   int              cycle_cnt;
   integer          seed;
   logic [31:0]     r_addr;
   logic [31:0]     r_ctl;
   addr_pkg::addr_t addr_v;

   // reference model state
   addr_pkg::addr_t model_ar;
   addr_pkg::addr_t model_ab;
   logic            model_naindex;
   logic            was_reset;
   out_set_t        predicted;
   out_set_t        exp_out;
   // outputs still travelling down the three stages
   out_set_t        expect_q[$];

   // device page probes
   // the first four hit devices 0 to 3
   addr_pkg::addr_t dev_addrs [12] = '{
      16'h0000, 16'h0100, 16'h0200, 16'h0300, 16'h0400, 16'h0500,
      16'h0600, 16'h07ff, 16'h0800, 16'h0b00, 16'h8300, 16'hf100
   };

   addr_path_top addr_path_top_inst (
      .clk     (clk),
      .arst_n  (arst_n),
      .ibus    (ibus),
      .nwar    (nwar),
      .nmem    (nmem),
      .nio     (nio),
      .nend    (nend),
      .ar      (ar),
      .ab      (ab),
      .ab_en   (ab_en),
      .nsysdev (nsysdev),
      .niodev1 (niodev1),
      .niodev2 (niodev2),
      .niodev3 (niodev3),
      .naindex (naindex)
   );

   always #CLK_HALF clk = ~clk;

   //////////////////////////////////////////////////////////////////////
   // reference model
   //////////////////////////////////////////////////////////////////////

   // outputs for one item given the register after this edge
   function automatic out_set_t predict_outputs(
      input addr_pkg::addr_t reg_v,
      input logic            loaded,
      input logic            nmem_v,
      input logic            nio_v,
      input logic            nend_v,
      input addr_pkg::addr_t held_ab,
      input logic            held_naindex
   );
      out_set_t o;
      logic [2:0] dev;
      // memory cycle or I/O cycle running
      o.ab_en   = !nmem_v || !nio_v;
      o.ab      = o.ab_en ? reg_v : held_ab;
      o.nsysdev = 1'b1;
      o.niodev  = 3'b111;
      dev       = reg_v[`DEV_SEL_HI:`DEV_SEL_LO];
      // device page is 0x0000 to 0x07ff
      if (!nio_v && reg_v[`DEV_PAGE_HI:`DEV_PAGE_LO] == '0) begin
         case (dev)
            3'd0: o.nsysdev = 1'b0;
            3'd1: o.niodev[1] = 1'b0;
            3'd2: o.niodev[2] = 1'b0;
            3'd3: o.niodev[3] = 1'b0;
            default: o.nsysdev = 1'b1;
         endcase
      end
      // end of instruction wins over a set
      if (!nend_v) begin
         o.naindex = 1'b1;
      end else if (loaded && reg_v[`AIDX_HI:`AIDX_LO] == `AIDX_PATTERN) begin
         o.naindex = 1'b0;
      end else begin
         o.naindex = held_naindex;
      end
      return o;
   endfunction

   task automatic compare_value(input string name, input logic [15:0] exp,
                                input logic [15:0] act);
      assert (act === exp) else begin
         errors++;
         $display("MISMATCH at %0t: %s expected %0h got %0h", $time, name, exp, act);
      end
   endtask

   // model steps on the rising edge
   // DUT is checked on the falling edge
   always begin
      @(posedge clk);
      was_reset = !arst_n;
      if (was_reset) begin
         model_ar      = '0;
         model_ab      = '0;
         model_naindex = 1'b1;
         expect_q      = {OUT_IDLE, OUT_IDLE};
      end else begin
         if (!nwar) begin
            model_ar = ibus;
         end
         predicted = predict_outputs(model_ar, !nwar, nmem, nio, nend,
                                     model_ab, model_naindex);
         model_ab      = predicted.ab;
         model_naindex = predicted.naindex;
         expect_q.push_back(predicted);
      end
      @(negedge clk);
      exp_out = was_reset ? OUT_IDLE : expect_q.pop_front();
      compare_value("ar", model_ar, ar);
      compare_value("ab", exp_out.ab, ab);
      compare_value("ab_en", exp_out.ab_en, ab_en);
      compare_value("nsysdev", exp_out.nsysdev, nsysdev);
      compare_value("niodev1", exp_out.niodev[1], niodev1);
      compare_value("niodev2", exp_out.niodev[2], niodev2);
      compare_value("niodev3", exp_out.niodev[3], niodev3);
      compare_value("naindex", exp_out.naindex, naindex);
   end

   //////////////////////////////////////////////////////////////////////
   // stimulus helpers
   //////////////////////////////////////////////////////////////////////

   // one sampled cycle driven 1 ns after a rising edge
   task automatic apply_cycle(input addr_pkg::addr_t bus_v, input logic nwar_v,
                              input logic nmem_v, input logic nio_v, input logic nend_v);
      ibus = bus_v;
      nwar = nwar_v;
      nmem = nmem_v;
      nio  = nio_v;
      nend = nend_v;
      @(posedge clk);
      #1;
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) apply_cycle(16'h0000, 1'b1, 1'b1, 1'b1, 1'b1);
   endtask

   // drain the pipe and report this test
   task automatic close_test(input string name);
      int fails_now;
      idle_cycles(3);
      // failures of the bound protocol checks count as errors too
      fails_now = addr_path_top_inst.addr_path_assertions_inst.fail_count;
      errors += fails_now - assert_fails_seen;
      assert_fails_seen = fails_now;
      tests++;
      if (errors == test_start_errors) begin
         $display("test %s passed", name);
      end else begin
         $display("test %s failed with %0d errors", name, errors - test_start_errors);
      end
      test_start_errors = errors;
   endtask

   //////////////////////////////////////////////////////////////////////
   // tests
   //////////////////////////////////////////////////////////////////////

   initial begin
      clk = 1'b0;
      arst_n = 1'b1;
      ibus = '0;
      nwar = 1'b1;
      nmem = 1'b1;
      nio = 1'b1;
      nend = 1'b1;
      errors = 0;
      tests = 0;
      test_start_errors = 0;
      assert_fails_seen = 0;
      seed = 93903;
      #1 arst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      #1 arst_n = 1'b1;
      idle_cycles(4);
      close_test("reset state");

      // loads only with the strobe low
      apply_cycle(16'h1234, 1'b0, 1'b1, 1'b1, 1'b1);
      idle_cycles(3);
      apply_cycle(16'hbeef, 1'b0, 1'b1, 1'b1, 1'b1);
      repeat (3) apply_cycle(16'h5555, 1'b1, 1'b1, 1'b1, 1'b1);
      apply_cycle(16'h0042, 1'b0, 1'b1, 1'b1, 1'b1);
      close_test("address register");

      // ab follows memory and I/O cycles and holds in between
      apply_cycle(16'h4321, 1'b0, 1'b0, 1'b1, 1'b1);
      idle_cycles(2);
      apply_cycle(16'h7777, 1'b0, 1'b1, 1'b1, 1'b1);
      idle_cycles(2);
      apply_cycle(16'h0000, 1'b1, 1'b0, 1'b1, 1'b1);
      apply_cycle(16'h2468, 1'b0, 1'b1, 1'b0, 1'b1);
      idle_cycles(2);
      close_test("bus drive and hold");

      foreach (dev_addrs[i]) begin
         apply_cycle(dev_addrs[i], 1'b0, 1'b1, 1'b0, 1'b1);
      end
      // device address without an I/O cycle
      apply_cycle(16'h0100, 1'b0, 1'b0, 1'b1, 1'b1);
      apply_cycle(16'h0300, 1'b1, 1'b1, 1'b1, 1'b1);
      close_test("device decode");

      apply_cycle(16'h0080, 1'b0, 1'b1, 1'b1, 1'b1);
      idle_cycles(2);
      // non-matching load keeps the flag
      apply_cycle(16'h1234, 1'b0, 1'b0, 1'b1, 1'b1);
      idle_cycles(2);
      apply_cycle(16'h0000, 1'b1, 1'b1, 1'b1, 1'b0);
      apply_cycle(16'h00ff, 1'b0, 1'b1, 1'b1, 1'b1);
      apply_cycle(16'h0000, 1'b1, 1'b1, 1'b1, 1'b0);
      apply_cycle(16'h007f, 1'b0, 1'b1, 1'b1, 1'b1);
      apply_cycle(16'h0100, 1'b0, 1'b1, 1'b1, 1'b1);
      apply_cycle(16'h8080, 1'b0, 1'b1, 1'b1, 1'b1);
      // set and clear on the same item
      apply_cycle(16'h00c0, 1'b0, 1'b1, 1'b1, 1'b0);
      idle_cycles(2);
      close_test("autoindex");

      for (int i = 0; i < RANDOM_CYCLES; i++) begin
         r_addr = $random(seed);
         r_ctl  = $random(seed);
         // half the addresses land in pages 0x00 to 0x07
         if (r_ctl[0]) begin
            addr_v = {5'b00000, r_addr[10:0]};
         end else begin
            addr_v = r_addr[15:0];
         end
         apply_cycle(addr_v, r_ctl[1], r_ctl[2], r_ctl[3], r_ctl[6:4] != 3'd0);
      end
      close_test("random run");

      $display("%0d tests run, %0d errors", tests, errors);
      if (errors == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

   // hang guard
   initial begin
      cycle_cnt = 0;
      while (cycle_cnt < CYCLE_LIMIT) begin
         @(posedge clk);
         cycle_cnt++;
      end
      $display("run exceeded the cycle limit of %0d cycles", CYCLE_LIMIT);
      $display("ERRORS FOUND");
      $finish;
   end

endmodule

`default_nettype wire

// File: sources.f
+incdir+verilog
verilog/addr_pkg.sv
verilog/addr_register.sv
verilog/addr_decode.sv
verilog/addr_bus_drive.sv
verilog/addr_path_top.sv
bench/addr_path_assertions.sv
bench/addr_path_tb.sv

// File: Bender.yml
package:
  name: addr_path

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/addr_pkg.sv
      - verilog/addr_register.sv
      - verilog/addr_decode.sv
      - verilog/addr_bus_drive.sv
      - verilog/addr_path_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - bench/addr_path_assertions.sv
      - bench/addr_path_tb.sv
